// ==== verilog.f ====
+incdir+verilog
verilog/exec_pkg.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/operand_select.sv
verilog/execute_stage.sv
verilog/execute_top.sv
verif/exec_assert.sv
verif/exec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the execute pipeline testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module exec_tb \
    -o exec_tb_sim

# exit status of the simulation is the test result
./obj_dir/exec_tb_sim

// ==== verif/exec_tb.sv ====
// testbench for the integer execute pipeline, reference model against registered results
`timescale 1ns/100ps

`include "exec_cfg.svh"

module exec_tb;

    localparam int          RESET_CYCLES = 4;
    localparam int          NUM_RANDOM   = 400;
    localparam int          MAX_GAP      = 3;
    localparam int          NUM_DIRECTED = 150; // upper bound on directed cycles
    localparam logic [31:0] SEED         = 32'hd5e029a3;
    localparam logic [31:0] SIGN         = 32'h8000_0000;

    typedef struct packed {
        exec_pkg::wb_t wb;
        logic [31:0]   cycle; // cycle count when the op was driven
    } expect_t;

    logic                  clk_i;
    logic                  rst_i;
    logic                  valid_i;
    exec_pkg::issue_t      issue_i;
    logic [`EXEC_XLEN-1:0] ext_fwd_value_i;
    logic                  wb_valid_o;
    exec_pkg::wb_t         wb_o;

    expect_t               exp_q[$];
    expect_t               cmp_entry;
    logic [31:0]           cycle_cnt;
    logic [`EXEC_XLEN-1:0] last_value; // model of the result seen by FWD_WB
    logic                  d1_valid;   // op driven one step ago
    logic                  d2_valid;   // op driven two steps ago
    exec_pkg::wb_t         d1_wb;
    exec_pkg::wb_t         d2_wb;

    execute_top u_execute_top (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .valid_i         (valid_i),
        .issue_i         (issue_i),
        .ext_fwd_value_i (ext_fwd_value_i),
        .wb_valid_o      (wb_valid_o),
        .wb_o            (wb_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 32'd1;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "result mismatch");
        end
    endtask

    function automatic logic [31:0] pick_operand(input exec_pkg::fwd_sel_e sel,
            input logic [31:0] reg_value, input logic [31:0] wb_value,
            input logic [31:0] ext_value);
        if (sel == exec_pkg::FWD_WB) begin
            return wb_value;
        end else if (sel == exec_pkg::FWD_EXT) begin
            return ext_value;
        end
        return reg_value; // select 3 acts as register value
    endfunction

    function automatic exec_pkg::wb_t ref_execute(input exec_pkg::issue_t op,
            input logic [`EXEC_XLEN-1:0] last_wb, input logic [`EXEC_XLEN-1:0] ext);
        logic [31:0]   a;
        logic [31:0]   rs2;
        logic [31:0]   b;
        logic [31:0]   res;
        logic          cond;
        exec_pkg::wb_t w;
        a   = pick_operand(op.fwd_a, op.rs1_value, last_wb, ext);
        rs2 = pick_operand(op.fwd_b, op.rs2_value, last_wb, ext);
        b   = op.uop.use_imm ? op.imm : rs2;
        case (op.uop.alu_op)
            exec_pkg::ALU_ADD:   res = a + b;
            exec_pkg::ALU_SUB:   res = a - b;
            exec_pkg::ALU_AND:   res = a & b;
            exec_pkg::ALU_OR:    res = a | b;
            exec_pkg::ALU_XOR:   res = a ^ b;
            exec_pkg::ALU_SLL:   res = a << b[4:0];
            exec_pkg::ALU_SRL:   res = a >> b[4:0];
            exec_pkg::ALU_SRA:   res = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            exec_pkg::ALU_SLT:   res = ((a ^ SIGN) < (b ^ SIGN)) ? 32'd1 : 32'd0;
            exec_pkg::ALU_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
            exec_pkg::ALU_LUI:   res = b;
            exec_pkg::ALU_AUIPC: res = op.pc + b;
            default:             res = '0;
        endcase
        case (op.uop.br_op)
            exec_pkg::BR_BEQ:  cond = a == rs2;
            exec_pkg::BR_BNE:  cond = a != rs2;
            exec_pkg::BR_BLT:  cond = (a ^ SIGN) < (rs2 ^ SIGN); // signed via bias
            exec_pkg::BR_BGE:  cond = (a ^ SIGN) >= (rs2 ^ SIGN);
            exec_pkg::BR_BLTU: cond = a < rs2;
            exec_pkg::BR_BGEU: cond = a >= rs2;
            default:           cond = 1'b1;
        endcase
        w = '0;
        w.rd_addr = op.rd_addr;
        case (op.uop.unit)
            exec_pkg::UNIT_ALU: begin
                w.rd_value = res;
                w.rd_write = op.rd_addr != '0;
            end
            exec_pkg::UNIT_BRANCH: begin
                w.br_taken  = cond;
                w.br_target = op.pc + op.imm;
            end
            exec_pkg::UNIT_JUMP: begin
                w.rd_value  = op.pc + (op.uop.compressed ? 32'd2 : 32'd4);
                w.rd_write  = op.rd_addr != '0;
                w.br_taken  = 1'b1;
                w.br_target = (op.uop.br_op == exec_pkg::BR_JALR) ?
                              ((a + op.imm) & ~32'd1) : op.pc + op.imm;
            end
            default: begin
            end
        endcase
        return w;
    endfunction

    function automatic exec_pkg::issue_t make_op(input exec_pkg::unit_e unit,
            input logic [3:0] alu_op, input logic [2:0] br_op, input logic [31:0] rs1,
            input logic [31:0] rs2, input logic [31:0] imm, input logic use_imm);
        exec_pkg::issue_t op;
        op                = '0;
        op.uop.unit       = unit;
        op.uop.alu_op     = exec_pkg::alu_op_e'(alu_op);
        op.uop.br_op      = exec_pkg::br_op_e'(br_op);
        op.uop.use_imm    = use_imm;
        op.rd_addr        = 5'd7;
        op.pc             = 32'h0000_2a40;
        op.rs1_value      = rs1;
        op.rs2_value      = rs2;
        op.imm            = imm;
        return op;
    endfunction

    function automatic exec_pkg::issue_t random_op();
        exec_pkg::issue_t op;
        logic [31:0]      r;
        r              = $urandom();
        op             = '0;
        op.uop.unit    = exec_pkg::unit_e'(r[1:0]);
        op.uop.alu_op  = exec_pkg::alu_op_e'(r[7:4] % 4'd12);
        op.uop.br_op   = exec_pkg::br_op_e'((op.uop.unit == exec_pkg::UNIT_JUMP) ?
                                            {2'b11, r[8]} : r[11:9] % 3'd6);
        op.uop.use_imm = r[12];
        op.uop.compressed = r[13];
        op.rd_addr     = r[18:14];
        op.fwd_a       = exec_pkg::fwd_sel_e'(r[20:19]);
        op.fwd_b       = exec_pkg::fwd_sel_e'(r[22:21]);
        op.pc          = $urandom() & 32'hffff_fffe;
        op.rs1_value   = $urandom();
        op.rs2_value   = r[23] ? op.rs1_value : $urandom(); // equal operands now and then
        op.imm         = $urandom();
        return op;
    endfunction

    // one negedge step, model sees results of ops driven two steps back
    task automatic drive_cycle(input logic valid, input exec_pkg::issue_t op,
                               input logic [`EXEC_XLEN-1:0] ext);
        exec_pkg::wb_t exp_wb;
        expect_t       entry;
        @(negedge clk_i);
        if (d2_valid) begin
            last_value = d2_wb.rd_value;
        end
        exp_wb          = ref_execute(op, last_value, ext);
        valid_i         = valid;
        issue_i         = op;
        ext_fwd_value_i = ext;
        if (valid) begin
            entry.wb    = exp_wb;
            entry.cycle = cycle_cnt;
            exp_q.push_back(entry);
        end
        d2_valid = d1_valid;
        d2_wb    = d1_wb;
        d1_valid = valid;
        d1_wb    = exp_wb;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0, '0);
    endtask

    task automatic apply_reset();
        @(negedge clk_i);
        rst_i   = 1'b1;
        valid_i = 1'b0;
        if (d1_valid) begin
            exp_q.delete(exp_q.size() - 1); // op in the operand stage is dropped
        end
        d1_valid   = 1'b0;
        d2_valid   = 1'b0;
        last_value = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;
        check_value("wb_valid_o after reset", 32'(wb_valid_o), 32'd0);
        check_value("wb_o after reset", 32'(|wb_o), 32'd0);
    endtask

    // result compare, outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (wb_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("tests failed");
                $fatal(1, "a result appeared with no operation pending");
            end else begin
                cmp_entry = exp_q.pop_front();
                check_value("rd_addr", 32'(wb_o.rd_addr), 32'(cmp_entry.wb.rd_addr));
                check_value("rd_value", wb_o.rd_value, cmp_entry.wb.rd_value);
                check_value("rd_write", 32'(wb_o.rd_write), 32'(cmp_entry.wb.rd_write));
                check_value("br_taken", 32'(wb_o.br_taken), 32'(cmp_entry.wb.br_taken));
                check_value("br_target", wb_o.br_target, cmp_entry.wb.br_target);
                check_value("latency", cycle_cnt, cmp_entry.cycle + 32'd2);
            end
        end
    end

    initial begin
        #((NUM_DIRECTED + NUM_RANDOM * (MAX_GAP + 1) + 50) * 10);
        $display("tests failed");
        $fatal(1, "watchdog timeout, the run did not finish in time");
    end

    initial begin
        exec_pkg::issue_t op;
        logic [31:0]      r;
        clk_i           = 1'b0;
        rst_i           = 1'b1;
        valid_i         = 1'b0;
        issue_i         = '0;
        ext_fwd_value_i = '0;
        cycle_cnt       = '0;
        d1_valid        = 1'b0;
        d2_valid        = 1'b0;
        d1_wb           = '0;
        d2_wb           = '0;
        last_value      = '0;
        void'($urandom(SEED));
        apply_reset();

        // every ALU op with register then immediate operand b, negative rs1
        for (int i = 0; i < 24; i++) begin
            drive_cycle(1'b1, make_op(exec_pkg::UNIT_ALU, 4'(i % 12), 3'd0, 32'h8000_00f3,
                                      32'hffff_fffd, 32'h0001_2004, i >= 12), '0);
        end
        op         = make_op(exec_pkg::UNIT_ALU, 4'd0, 3'd0, 32'd1, 32'd2, 32'd0, 1'b0);
        op.rd_addr = '0; // x0 target, no write
        drive_cycle(1'b1, op, '0);

        // conditional branches on equal, signed-less and unsigned-less pairs
        for (int p = 0; p < 3; p++) begin
            for (int i = 0; i < 6; i++) begin
                drive_cycle(1'b1, make_op(exec_pkg::UNIT_BRANCH, 4'd0, 3'(i),
                    (p == 0) ? 32'd5 : (p == 1) ? 32'hffff_fffd : 32'd2,
                    (p == 0) ? 32'd5 : (p == 1) ? 32'd2 : 32'hffff_fffd,
                    32'hffff_ff80, p == 2), '0);
            end
        end

        // jal and jalr, full size and compressed
        for (int i = 0; i < 4; i++) begin
            op = make_op(exec_pkg::UNIT_JUMP, 4'd0, i[0] ? 3'd7 : 3'd6, 32'h0000_3001,
                         32'd0, 32'h0000_0102, 1'b1);
            op.uop.compressed = i[1];
            drive_cycle(1'b1, op, '0);
        end

        // forwarding selects 0..3, back to back then a gap
        for (int f = 0; f < 4; f++) begin
            op       = make_op(exec_pkg::UNIT_ALU, 4'd0, 3'd0, 32'h100 + 32'(f), 32'h10,
                               32'd0, 1'b0);
            op.fwd_a = exec_pkg::fwd_sel_e'(2'(f));
            op.fwd_b = exec_pkg::fwd_sel_e'(2'(3 - f));
            drive_cycle(1'b1, op, 32'h5000_0000 + 32'(f));
            drive_cycle(1'b1, op, 32'h0600_0000);
            idle_cycles(1);
        end

        repeat (20) drive_cycle(1'b1, random_op(), $urandom()); // full rate

        repeat (3) drive_cycle(1'b1, random_op(), $urandom());
        apply_reset(); // reset with ops in flight

        for (int n = 0; n < NUM_RANDOM; n++) begin
            drive_cycle(1'b1, random_op(), $urandom());
            r = $urandom();
            idle_cycles(r % (MAX_GAP + 1));
        end
        idle_cycles(4);

        if (exp_q.size() != 0) begin
            $display("tests failed");
            $fatal(1, "%0d expected results never appeared", exp_q.size());
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== verif/exec_assert.sv ====
// concurrent checks on the execute pipeline outputs, bound into the top level
`timescale 1ns/100ps

module exec_assert (
    input logic          clk_i,
    input logic          rst_i,
    input logic          valid_i,
    input logic          wb_valid_o,
    input exec_pkg::wb_t wb_o
);

    // nothing valid in the first cycle out of reset
    no_valid_after_reset: assert property (@(posedge clk_i)
        $past(rst_i) && !rst_i |-> !wb_valid_o)
        else $error("wb_valid_o high in the first cycle after reset");

    valid_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        !$past(rst_i, 1) && !$past(rst_i, 2) |-> wb_valid_o == $past(valid_i, 2))
        else $error("wb_valid_o does not follow valid_i by two cycles");

    no_write_to_x0: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_o.rd_write |-> wb_o.rd_addr != '0)
        else $error("write flag set with rd zero");

    // last result holds while nothing completes
    result_holds: assert property (@(posedge clk_i) disable iff (rst_i)
        !wb_valid_o && !$past(rst_i) |-> $stable(wb_o))
        else $error("wb_o changed while wb_valid_o was low");

endmodule

bind execute_top exec_assert u_exec_assert (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (valid_i),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o)
);

// ==== verilog/execute_top.sv ====
// integer execute top, operand stage and execute stage with result forwarding
`timescale 1ns/100ps

`include "exec_cfg.svh"

module execute_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  valid_i,
    input  exec_pkg::issue_t      issue_i,
    input  logic [`EXEC_XLEN-1:0] ext_fwd_value_i, // e.g. from a memory stage
    output logic                  wb_valid_o,
    output exec_pkg::wb_t         wb_o
);

    logic                op_valid;
    exec_pkg::operands_t operands;

    // stage 1, forwarding and operand b choice
    operand_select u_operand_select (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .valid_i         (valid_i),
        .issue_i         (issue_i),
        .wb_value_i      (wb_o.rd_value), // loop back of the registered result
        .ext_fwd_value_i (ext_fwd_value_i),
        .op_valid_o      (op_valid),
        .operands_o      (operands)
    );

    // stage 2, alu / branch and write-back register
    execute_stage u_execute_stage (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .op_valid_i (op_valid),
        .operands_i (operands),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

endmodule

// ==== verilog/execute_stage.sv ====
// execute stage, runs ALU and branch unit, selects result and registers write-back
`timescale 1ns/100ps

`include "exec_cfg.svh"

module execute_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                op_valid_i,
    input  exec_pkg::operands_t operands_i,
    output logic                wb_valid_o,
    output exec_pkg::wb_t       wb_o
);

    logic [`EXEC_XLEN-1:0] alu_result;
    logic                  br_taken;
    logic [`EXEC_XLEN-1:0] br_target;
    logic [`EXEC_XLEN-1:0] br_link;
    logic                  rd_nonzero;
    exec_pkg::wb_t         wb_d;

    alu u_alu (
        .op_i     (operands_i.uop.alu_op),
        .a_i      (operands_i.op_a),
        .b_i      (operands_i.op_b),
        .pc_i     (operands_i.pc),
        .result_o (alu_result)
    );

    branch_unit u_branch_unit (
        .op_i         (operands_i.uop.br_op),
        .rs1_i        (operands_i.op_a),
        .rs2_i        (operands_i.rs2_value),
        .pc_i         (operands_i.pc),
        .imm_i        (operands_i.imm),
        .compressed_i (operands_i.uop.compressed),
        .taken_o      (br_taken),
        .target_o     (br_target),
        .link_o       (br_link)
    );

    assign rd_nonzero = |operands_i.rd_addr; // x0 is never written

    always_comb begin
        wb_d.rd_addr = operands_i.rd_addr;
        case (operands_i.uop.unit)
            exec_pkg::UNIT_ALU: begin
                wb_d.rd_value  = alu_result;
                wb_d.rd_write  = rd_nonzero;
                wb_d.br_taken  = 1'b0;
                wb_d.br_target = '0;
            end
            exec_pkg::UNIT_BRANCH: begin
                wb_d.rd_value  = '0;
                wb_d.rd_write  = 1'b0;
                wb_d.br_taken  = br_taken;
                wb_d.br_target = br_target;
            end
            exec_pkg::UNIT_JUMP: begin
                wb_d.rd_value  = br_link;
                wb_d.rd_write  = rd_nonzero;
                wb_d.br_taken  = 1'b1;
                wb_d.br_target = br_target;
            end
            default: begin
                wb_d.rd_value  = '0;
                wb_d.rd_write  = 1'b0;
                wb_d.br_taken  = 1'b0;
                wb_d.br_target = '0;
            end
        endcase
    end

    // holds the last completed result, also the forwarding source
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_o       <= '0;
        end else begin
            wb_valid_o <= op_valid_i;
            if (op_valid_i) begin
                wb_o <= wb_d;
            end
        end
    end

endmodule

// ==== verilog/operand_select.sv ====
// operand stage, resolves forwarding and the immediate choice, registers operands
`timescale 1ns/100ps

`include "exec_cfg.svh"

module operand_select (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  valid_i,
    input  exec_pkg::issue_t      issue_i,
    input  logic [`EXEC_XLEN-1:0] wb_value_i,      // last completed result
    input  logic [`EXEC_XLEN-1:0] ext_fwd_value_i,
    output logic                  op_valid_o,
    output exec_pkg::operands_t   operands_o
);

    exec_pkg::operands_t  operands_d;
    logic [`EXEC_XLEN-1:0] rs1_fwd;
    logic [`EXEC_XLEN-1:0] rs2_fwd;

    // three-way forward mux, unknown select keeps the register file value
    function automatic logic [`EXEC_XLEN-1:0] fwd_mux(
        input exec_pkg::fwd_sel_e     sel,
        input logic [`EXEC_XLEN-1:0] reg_val,
        input logic [`EXEC_XLEN-1:0] wb_val,
        input logic [`EXEC_XLEN-1:0] ext_val
    );
        case (sel)
            exec_pkg::FWD_WB:  return wb_val;
            exec_pkg::FWD_EXT: return ext_val;
            default:           return reg_val;
        endcase
    endfunction

    always_comb begin
        rs1_fwd = fwd_mux(issue_i.fwd_a, issue_i.rs1_value, wb_value_i, ext_fwd_value_i);
        rs2_fwd = fwd_mux(issue_i.fwd_b, issue_i.rs2_value, wb_value_i, ext_fwd_value_i);

        operands_d.uop       = issue_i.uop;
        operands_d.rd_addr   = issue_i.rd_addr;
        operands_d.pc        = issue_i.pc;
        operands_d.op_a      = rs1_fwd;
        operands_d.op_b      = issue_i.uop.use_imm ? issue_i.imm : rs2_fwd;
        operands_d.rs2_value = rs2_fwd; // branches compare rs2 even with an imm
        operands_d.imm       = issue_i.imm;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            op_valid_o <= 1'b0;
        end else begin
            op_valid_o <= valid_i;
        end
    end

    // operand payload, qualified downstream by op_valid_o
    always_ff @(posedge clk_i) begin
        operands_o <= operands_d;
    end

endmodule

// ==== verilog/branch_unit.sv ====
// branch unit, evaluates branch conditions and forms jump targets and link address
`timescale 1ns/100ps

`include "exec_cfg.svh"

module branch_unit (
    input  exec_pkg::br_op_e      op_i,
    input  logic [`EXEC_XLEN-1:0] rs1_i,
    input  logic [`EXEC_XLEN-1:0] rs2_i,
    input  logic [`EXEC_XLEN-1:0] pc_i,
    input  logic [`EXEC_XLEN-1:0] imm_i,
    input  logic                  compressed_i,
    output logic                  taken_o,
    output logic [`EXEC_XLEN-1:0] target_o,
    output logic [`EXEC_XLEN-1:0] link_o
);

    logic                  eq;
    logic                  lt_s;
    logic                  lt_u;
    logic [`EXEC_XLEN-1:0] pc_rel;
    logic [`EXEC_XLEN-1:0] reg_rel;

    assign eq      = rs1_i == rs2_i;
    assign lt_s    = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u    = rs1_i < rs2_i;
    assign pc_rel  = pc_i + imm_i;
    assign reg_rel = rs1_i + imm_i;

    always_comb begin
        case (op_i)
            exec_pkg::BR_BEQ:  taken_o = eq;
            exec_pkg::BR_BNE:  taken_o = !eq;
            exec_pkg::BR_BLT:  taken_o = lt_s;
            exec_pkg::BR_BGE:  taken_o = !lt_s;
            exec_pkg::BR_BLTU: taken_o = lt_u;
            exec_pkg::BR_BGEU: taken_o = !lt_u;
            default:           taken_o = 1'b1; // jal and jalr always redirect
        endcase
    end

    // only jalr is register relative
    assign target_o = (op_i == exec_pkg::BR_JALR) ?
                      {reg_rel[`EXEC_XLEN-1:1], 1'b0} : pc_rel;

    // return address skips the current instruction
    assign link_o = pc_i + (compressed_i ? `EXEC_XLEN'(`EXEC_LINK_STEP_C)
                                         : `EXEC_XLEN'(`EXEC_LINK_STEP));

endmodule

// ==== verilog/alu.sv ====
// integer ALU, arithmetic, logic, shifts, compares, LUI and AUIPC
`timescale 1ns/100ps

`include "exec_cfg.svh"

module alu (
    input  exec_pkg::alu_op_e     op_i,
    input  logic [`EXEC_XLEN-1:0] a_i,
    input  logic [`EXEC_XLEN-1:0] b_i,
    input  logic [`EXEC_XLEN-1:0] pc_i,
    output logic [`EXEC_XLEN-1:0] result_o
);

    logic [`EXEC_SHAMT_W-1:0] shamt;
    logic                     lt_signed;
    logic                     lt_unsigned;

    assign shamt       = b_i[`EXEC_SHAMT_W-1:0]; // only the low bits shift
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            exec_pkg::ALU_ADD: begin
                result_o = a_i + b_i;
            end
            exec_pkg::ALU_SUB: begin
                result_o = a_i - b_i;
            end
            exec_pkg::ALU_AND: begin
                result_o = a_i & b_i;
            end
            exec_pkg::ALU_OR: begin
                result_o = a_i | b_i;
            end
            exec_pkg::ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            exec_pkg::ALU_SLL: begin
                result_o = a_i << shamt;
            end
            exec_pkg::ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            exec_pkg::ALU_SRA: begin
                // sign bit fills from the left
                result_o = $unsigned($signed(a_i) >>> shamt);
            end
            exec_pkg::ALU_SLT: begin
                result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            end
            exec_pkg::ALU_SLTU: begin
                result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            end
            exec_pkg::ALU_LUI: begin
                result_o = b_i; // decode already shifted the upper imm
            end
            exec_pkg::ALU_AUIPC: begin
                result_o = pc_i + b_i;
            end
            default: begin
                result_o = '0; // unused encodings 12..15
            end
        endcase
    end

endmodule

// ==== verilog/exec_pkg.sv ====
// execute subsystem types, op encodings and the bundles passed between stages

`include "exec_cfg.svh"

package exec_pkg;

    typedef enum logic [`EXEC_UNIT_W-1:0] {
        UNIT_NONE   = 2'd0, // no write
        UNIT_ALU    = 2'd1,
        UNIT_BRANCH = 2'd2, // conditional branch, no write
        UNIT_JUMP   = 2'd3  // jal / jalr, writes link
    } unit_e;

    typedef enum logic [`EXEC_ALU_OP_W-1:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_LUI   = 4'd10, // passes operand b
        ALU_AUIPC = 4'd11  // pc + operand b
    } alu_op_e;

    typedef enum logic [`EXEC_BR_OP_W-1:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,
        BR_BGE  = 3'd3,
        BR_BLTU = 3'd4,
        BR_BGEU = 3'd5,
        BR_JAL  = 3'd6, // target pc + imm
        BR_JALR = 3'd7  // target rs1 + imm, bit 0 cleared
    } br_op_e;

    // value 3 is not named and falls back to the register value
    typedef enum logic [`EXEC_FWD_W-1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_EXT = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        unit_e   unit;
        alu_op_e alu_op;
        br_op_e  br_op;
        logic    use_imm;
        logic    compressed;
    } micro_op_t;

    typedef struct packed {
        micro_op_t               uop;
        logic [`EXEC_REG_AW-1:0] rd_addr;
        logic [`EXEC_XLEN-1:0]   pc;
        logic [`EXEC_XLEN-1:0]   rs1_value;
        logic [`EXEC_XLEN-1:0]   rs2_value;
        logic [`EXEC_XLEN-1:0]   imm;
        fwd_sel_e                fwd_a;
        fwd_sel_e                fwd_b;
    } issue_t;

    typedef struct packed {
        micro_op_t               uop;
        logic [`EXEC_REG_AW-1:0] rd_addr;
        logic [`EXEC_XLEN-1:0]   pc;
        logic [`EXEC_XLEN-1:0]   op_a;
        logic [`EXEC_XLEN-1:0]   op_b;
        logic [`EXEC_XLEN-1:0]   rs2_value; // resolved rs2 for branch compares
        logic [`EXEC_XLEN-1:0]   imm;
    } operands_t;

    typedef struct packed {
        logic [`EXEC_REG_AW-1:0] rd_addr;
        logic [`EXEC_XLEN-1:0]   rd_value;
        logic                    rd_write;
        logic                    br_taken;
        logic [`EXEC_XLEN-1:0]   br_target;
    } wb_t;

endpackage

// ==== verilog/exec_cfg.svh ====
// execute subsystem configuration, data and register-address widths

`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// integer data path width
`define EXEC_XLEN 32

// architectural register address width (x0..x31)
`define EXEC_REG_AW 5

// per-operand forwarding select width
`define EXEC_FWD_W 2

// shift amount field taken from operand b
`define EXEC_SHAMT_W 5

// link address steps for compressed and full-size instructions
`define EXEC_LINK_STEP_C 2
`define EXEC_LINK_STEP 4

// ALU and branch op encodings are fixed by their enum widths
`define EXEC_UNIT_W 2
`define EXEC_ALU_OP_W 4
`define EXEC_BR_OP_W 3

`endif
